/* rtl/fetch_pkg.sv */
// fetch path definitions shared by the prefetch buffer blocks
// widths, the instruction word type and the control-transfer test
// that decides whether a second instruction may be paired behind it
`default_nettype none

package fetch_pkg;

  // one instruction word
  localparam int unsigned InstrW = 32;
  // a memory beat carries two instruction words, older one in the low half
  localparam int unsigned BeatW = 2 * InstrW;

  typedef logic [InstrW-1:0] instr_t;

  // major opcodes that redirect the fetch stream
  localparam logic [6:0] OpcJal    = 7'b1101111;
  localparam logic [6:0] OpcJalr   = 7'b1100111;
  localparam logic [6:0] OpcBranch = 7'b1100011;

  // true for jal, jalr and conditional branches
  function automatic logic is_ctrl_xfer(instr_t instr);
    logic [6:0] opc;
    opc = instr[6:0];
    return (opc == OpcJal) || (opc == OpcJalr) || (opc == OpcBranch);
  endfunction

endpackage

`default_nettype wire

/* rtl/dual_pair_if.sv */
// dual valid/ready pair with two instruction slots
// valid and rdy use the count code 00 none, 01 one, 11 two; 10 is illegal
// data0 always holds the older instruction
`timescale 1ns/1ps
`default_nettype none

interface dual_pair_if import fetch_pkg::*; ();

  // number of instructions offered by the sender
  logic [1:0] valid;
  // number of instructions the receiver can take
  logic [1:0] rdy;
  // older slot
  instr_t     data0;
  // younger slot, meaningful only with valid 11
  instr_t     data1;

  // producer side
  modport sender (
    output valid,
    output data0,
    output data1,
    input  rdy
  );

  // consumer side
  modport receiver (
    input  valid,
    input  data0,
    input  data1,
    output rdy
  );

endinterface

`default_nettype wire

/* rtl/fetch_unpack.sv */
// fetch beat unpacker
// holds one 64-bit memory beat and offers its one or two instructions
// to the FIFO, keeping the younger one when only one is taken
`timescale 1ns/1ps
`default_nettype none

module fetch_unpack import fetch_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             mem_valid_i,
  input  logic [BeatW-1:0] mem_data_i,
  input  logic             mem_odd_i,
  output logic             mem_rdy_o,
  dual_pair_if.sender      out_o
);

  // instructions still waiting in the beat register, 0 to 2
  logic [1:0] cnt_q, cnt_d;
  // beat payload, slot0 is the older remaining instruction
  instr_t     slot0_q, slot1_q;
  logic       mem_take;
  // instructions the FIFO accepts this cycle
  logic [1:0] acc_num;

  // ready only from local state, so no path from FIFO ready to memory
  assign mem_rdy_o = (cnt_q == 2'd0) & ~flush_i;
  assign mem_take  = mem_valid_i & mem_rdy_o;

  // offer the remaining count as a dual code
  always_comb begin
    case (cnt_q)
      2'd2:    out_o.valid = 2'b11;
      2'd1:    out_o.valid = 2'b01;
      default: out_o.valid = 2'b00;
    endcase
  end

  assign out_o.data0 = slot0_q;
  assign out_o.data1 = slot1_q;

  // two only when both sides say two, otherwise one on bit 0
  always_comb begin
    if ((out_o.valid == 2'b11) && (out_o.rdy == 2'b11)) begin
      acc_num = 2'd2;
    end else if (out_o.valid[0] && out_o.rdy[0]) begin
      acc_num = 2'd1;
    end else begin
      acc_num = 2'd0;
    end
  end

  // a new beat only lands in an empty register, so acc_num is 0 then
  always_comb begin
    if (mem_take) begin
      cnt_d = mem_odd_i ? 2'd1 : 2'd2;
    end else begin
      cnt_d = cnt_q - acc_num;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= 2'd0;
    end else if (flush_i) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // odd start keeps only the upper half, placed in the older slot
  // slot1 takes the upper half either way so it never floats
  always_ff @(posedge clk_i) begin
    if (mem_take) begin
      slot0_q <= mem_odd_i ? mem_data_i[BeatW-1:InstrW] : mem_data_i[InstrW-1:0];
      slot1_q <= mem_data_i[BeatW-1:InstrW];
    end else if ((cnt_q == 2'd2) && (acc_num == 2'd1)) begin
      // leftover younger instruction moves up and is offered alone
      slot0_q <= slot1_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/dual_fifo.sv */
// dual-issue instruction FIFO
// writes and reads zero, one or two entries per cycle over a flop array,
// with extended pointers for full/empty and a single-cycle flush
`timescale 1ns/1ps
`default_nettype none

module dual_fifo import fetch_pkg::*; #(
  // power of two, at least 2
  parameter int unsigned Depth = 4
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  dual_pair_if.receiver wr_i,
  dual_pair_if.sender   rd_o
);

  localparam int unsigned     AddrW   = $clog2(Depth);
  // one extra bit tells full from empty
  localparam int unsigned     PtrW    = AddrW + 1;
  localparam logic [PtrW-1:0] DepthM1 = PtrW'(Depth - 1);
  localparam logic [PtrW-1:0] DepthM2 = PtrW'(Depth - 2);

  logic [PtrW-1:0]  wr_ptr_q, wr_ptr_p1, wr_ptr_p2, wr_ptr_nxt;
  logic [PtrW-1:0]  rd_ptr_q, rd_ptr_p1, rd_ptr_p2, rd_ptr_nxt;
  // occupancy seen by the write side, after this cycle's reads
  logic [PtrW-1:0]  wr_level;
  // stored entries, drives the read side
  logic [PtrW-1:0]  rd_level;
  logic [AddrW-1:0] wr_addr0, wr_addr1;
  logic [AddrW-1:0] rd_addr0, rd_addr1;
  logic [1:0]       wr_en;

  instr_t mem_q [Depth];

  assign wr_ptr_p1 = wr_ptr_q + PtrW'(1);
  assign wr_ptr_p2 = wr_ptr_q + PtrW'(2);
  assign rd_ptr_p1 = rd_ptr_q + PtrW'(1);
  assign rd_ptr_p2 = rd_ptr_q + PtrW'(2);

  assign wr_level = wr_ptr_q - rd_ptr_nxt;
  assign rd_level = wr_ptr_q - rd_ptr_q;

  // storage addresses drop the wrap bit
  assign wr_addr0 = wr_ptr_q[AddrW-1:0];
  assign wr_addr1 = wr_ptr_p1[AddrW-1:0];
  assign rd_addr0 = rd_ptr_q[AddrW-1:0];
  assign rd_addr1 = rd_ptr_p1[AddrW-1:0];

  // free space as a legal ready code, bit 1 implies bit 0
  assign wr_i.rdy[1] = (wr_level <= DepthM2);
  assign wr_i.rdy[0] = (wr_level <= DepthM1);

  // fill level as a legal valid code
  assign rd_o.valid[1] = (rd_level >= PtrW'(2));
  assign rd_o.valid[0] = (rd_level >= PtrW'(1));

  // read side is combinational from the array
  assign rd_o.data0 = mem_q[rd_addr0];
  assign rd_o.data1 = mem_q[rd_addr1];

  always_comb begin
    // read pointer advance
    if ((rd_o.valid == 2'b11) && (rd_o.rdy == 2'b11)) begin
      rd_ptr_nxt = rd_ptr_p2;
    end else if (rd_o.valid[0] && rd_o.rdy[0]) begin
      rd_ptr_nxt = rd_ptr_p1;
    end else begin
      rd_ptr_nxt = rd_ptr_q;
    end

    // write pointer advance and per-slot enables
    if ((wr_i.rdy == 2'b11) && (wr_i.valid == 2'b11)) begin
      wr_ptr_nxt = wr_ptr_p2;
      wr_en      = 2'b11;
    end else if (wr_i.rdy[0] && wr_i.valid[0]) begin
      wr_ptr_nxt = wr_ptr_p1;
      wr_en      = 2'b01;
    end else begin
      wr_ptr_nxt = wr_ptr_q;
      wr_en      = 2'b00;
    end
  end

  // flush drops every entry by zeroing both pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_nxt;
      rd_ptr_q <= rd_ptr_nxt;
    end
  end

  // one write port pair per entry, slot0 lands at the write pointer
  for (genvar i = 0; i < Depth; i++) begin : gen_mem
    always_ff @(posedge clk_i) begin
      if (wr_en[0] && (wr_addr0 == AddrW'(i))) begin
        mem_q[i] <= wr_i.data0;
      end else if (wr_en[1] && (wr_addr1 == AddrW'(i))) begin
        mem_q[i] <= wr_i.data1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/issue_pair.sv */
// issue pairing stage between the FIFO head and decode
// holds back the second instruction behind a control transfer and
// returns decode's ready code, limited to what was offered
`timescale 1ns/1ps
`default_nettype none

module issue_pair import fetch_pkg::*; (
  dual_pair_if.receiver in_i,
  output logic [1:0]    iss_valid_o,
  output instr_t        iss_instr0_o,
  output instr_t        iss_instr1_o,
  input  logic [1:0]    iss_rdy_i
);

  // older head instruction redirects the stream
  logic       head_ctrl;
  // code actually offered to decode
  logic [1:0] offer;

  assign head_ctrl = is_ctrl_xfer(in_i.data0);

  // two drops to one when the head is a jump or branch
  always_comb begin
    if ((in_i.valid == 2'b11) && head_ctrl) begin
      offer = 2'b01;
    end else begin
      offer = in_i.valid;
    end
  end

  assign iss_valid_o  = offer;
  assign iss_instr0_o = in_i.data0;
  assign iss_instr1_o = in_i.data1;

  // never report more ready than offered
  // bit 1 also needs bit 0 so the returned code stays legal
  assign in_i.rdy[0] = iss_rdy_i[0] & offer[0];
  assign in_i.rdy[1] = iss_rdy_i[1] & iss_rdy_i[0] & offer[1];

endmodule

`default_nettype wire

/* rtl/fetch_buffer_top.sv */
// instruction prefetch buffer
// memory beats are unpacked, queued in a dual-issue FIFO and offered
// to decode one or two at a time; flush empties the path in one cycle
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_top import fetch_pkg::*; #(
  // FIFO entries, power of two
  parameter int unsigned Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  // memory beat side
  input  logic             mem_valid_i,
  input  logic [BeatW-1:0] mem_data_i,
  input  logic             mem_odd_i,
  output logic             mem_rdy_o,
  // decode side, dual count code
  output logic [1:0]       iss_valid_o,
  output instr_t           iss_instr0_o,
  output instr_t           iss_instr1_o,
  input  logic [1:0]       iss_rdy_i
);

  // unpacker to FIFO
  dual_pair_if unpack_q ();
  // FIFO to pairing stage
  dual_pair_if issue_q ();

  fetch_unpack fetch_unpack_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .mem_valid_i (mem_valid_i),
    .mem_data_i  (mem_data_i),
    .mem_odd_i   (mem_odd_i),
    .mem_rdy_o   (mem_rdy_o),
    .out_o       (unpack_q.sender)
  );

  dual_fifo #(
    .Depth (Depth)
  ) dual_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .wr_i    (unpack_q.receiver),
    .rd_o    (issue_q.sender)
  );

  issue_pair issue_pair_i (
    .in_i         (issue_q.receiver),
    .iss_valid_o  (iss_valid_o),
    .iss_instr0_o (iss_instr0_o),
    .iss_instr1_o (iss_instr1_o),
    .iss_rdy_i    (iss_rdy_i)
  );

endmodule

`default_nettype wire

/* dv/fetch_buffer_asserts.sv */
// FIFO-side checks for the prefetch buffer
// dual code legality, fill level bound and write-side stability
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_asserts import fetch_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   flush_i,
  input logic [1:0]             wr_valid_i,
  input logic [1:0]             wr_rdy_i,
  input instr_t                 wr_data0_i,
  input instr_t                 wr_data1_i,
  input logic [1:0]             rd_valid_i,
  input logic [1:0]             rd_rdy_i,
  input logic [$clog2(Depth):0] level_i
);

  // failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // 10 would be two without one
  a_codes_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_valid_i != 2'b10) && (wr_rdy_i != 2'b10) &&
    (rd_valid_i != 2'b10) && (rd_rdy_i != 2'b10))
    else begin
      fail_cnt++;
      $error("illegal dual code on the FIFO ports");
    end

  a_level_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_i <= Depth)
    else begin
      fail_cnt++;
      $error("FIFO fill level above depth");
    end

  // an offer nothing was taken from holds its code and both slots
  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_valid_i[0] && !wr_rdy_i[0] && !flush_i) |=>
      ($stable(wr_valid_i) && $stable(wr_data0_i) && $stable(wr_data1_i)))
    else begin
      fail_cnt++;
      $error("FIFO write offer changed while not accepted");
    end

endmodule

bind dual_fifo fetch_buffer_asserts #(.Depth(Depth)) asserts_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .flush_i    (flush_i),
  .wr_valid_i (wr_i.valid),
  .wr_rdy_i   (wr_i.rdy),
  .wr_data0_i (wr_i.data0),
  .wr_data1_i (wr_i.data1),
  .rd_valid_i (rd_o.valid),
  .rd_rdy_i   (rd_o.rdy),
  .level_i    (rd_level)
);

`default_nettype wire

/* dv/fetch_buffer_tb.sv */
// testbench for the instruction prefetch buffer
// random beats, decode stalls and flush pulses checked against a queue model
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_tb import fetch_pkg::*; ();

  localparam int unsigned Depth    = 4;
  localparam int unsigned RandCyc  = 250;
  localparam int unsigned StallCyc = 24;
  localparam int unsigned DrainCyc = 20;
  // reset, two random stretches, one stall stretch and the drain
  localparam int unsigned StimCyc  = 3 + 2 * RandCyc + StallCyc + DrainCyc;
  localparam int unsigned CycLimit = 4 * StimCyc + 100;

  logic             clk_i = 1'b0;
  logic             rst_ni, flush_i, mem_valid_i, mem_odd_i, mem_rdy_o;
  logic [BeatW-1:0] mem_data_i;
  logic [1:0]       iss_valid_o, iss_rdy_i;
  instr_t           iss_instr0_o, iss_instr1_o;

  // instructions still to issue, with the edge at which each beat was taken
  instr_t      exp_q[$];
  int unsigned stamp_q[$];
  int unsigned cyc = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned afail;
  logic [31:0] rnd = 32'h59380c28;
  logic [19:0] seq = '0;
  // idle state expected at the next sample
  bit          idle_chk = 1'b0;
  bit          stall_on = 1'b0;
  bit          saw_drop = 1'b0;

  always #4 clk_i = ~clk_i;

  fetch_buffer_top #(.Depth(Depth)) fetch_buffer_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .mem_valid_i  (mem_valid_i),
    .mem_data_i   (mem_data_i),
    .mem_odd_i    (mem_odd_i),
    .mem_rdy_o    (mem_rdy_o),
    .iss_valid_o  (iss_valid_o),
    .iss_instr0_o (iss_instr0_o),
    .iss_instr1_o (iss_instr1_o),
    .iss_rdy_i    (iss_rdy_i)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // RV32 jal, jalr and branch major opcodes
  function automatic bit redirects(instr_t ins);
    return (ins[6:0] == 7'h6f) || (ins[6:0] == 7'h67) || (ins[6:0] == 7'h63);
  endfunction

  // pairing rule over the instructions decode can already see
  function automatic logic [1:0] expected_issue(int unsigned n_vis, instr_t head);
    if (n_vis == 0) begin
      return 2'b00;
    end
    return ((n_vis == 1) || redirects(head)) ? 2'b01 : 2'b11;
  endfunction

  // sequence number on top, about one in four is a jump or branch
  function automatic instr_t make_instr(logic [19:0] num, logic [31:0] r);
    logic [6:0] opc;
    if (r[31:30] == 2'b00) begin
      opc = (r[29:28] == 2'd0) ? OpcJal : ((r[29:28] == 2'd1) ? OpcJalr : OpcBranch);
    end else begin
      opc = r[27] ? 7'b0110011 : 7'b0010011;
    end
    return {num, r[26:22], opc};
  endfunction

  task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // one stimulus cycle; mode 0 random, 1 decode stall, 2 drain
  task automatic drive_cycle(int mode);
    logic   took;
    instr_t lo, hi;
    @(negedge clk_i);
    took = mem_valid_i && mem_rdy_o;
    @(posedge clk_i);
    #1;
    rnd = lcg_next(rnd);
    flush_i = (mode == 0) && !flush_i && (rnd[27:23] == 5'd0);
    // a pending beat stays on the bus until memory ready takes it
    if (took || !mem_valid_i) begin
      mem_valid_i = (mode == 1) || ((mode == 0) && (rnd[29:28] != 2'b00));
      if (mem_valid_i) begin
        rnd = lcg_next(rnd);
        lo = make_instr(seq, rnd);
        rnd = lcg_next(rnd);
        hi = make_instr(seq + 20'd1, rnd);
        seq = seq + 20'd2;
        mem_data_i = {hi, lo};
        mem_odd_i = rnd[20];
      end
    end
    if (mode == 0) begin
      iss_rdy_i = (rnd[22:21] == 2'd0) ? 2'b00 : ((rnd[22:21] == 2'd1) ? 2'b01 : 2'b11);
    end else begin
      iss_rdy_i = (mode == 1) ? 2'b00 : 2'b11;
    end
  endtask

  // compare at mid cycle, then retire issued and queue accepted instructions
  always @(negedge clk_i) begin
    int unsigned n_vis;
    int unsigned n_pop;
    logic [1:0]  exp_code;
    if (!rst_ni || idle_chk) begin
      compare_value("iss_valid_o", 2'b00, iss_valid_o);
      compare_value("mem_rdy_o", 1'b1, mem_rdy_o);
    end
    idle_chk = !rst_ni;
    if (rst_ni) begin
      // a beat taken at edge n reaches the FIFO outputs after edge n+1
      n_vis = 0;
      while ((n_vis < 2) && (n_vis < exp_q.size()) && (stamp_q[n_vis] < cyc)) begin
        n_vis++;
      end
      exp_code = expected_issue(n_vis, (n_vis > 0) ? exp_q[0] : '0);
      compare_value("iss_valid_o", exp_code, iss_valid_o);
      if (exp_code[0]) begin
        compare_value("iss_instr0_o", exp_q[0], iss_instr0_o);
      end
      if (exp_code[1]) begin
        compare_value("iss_instr1_o", exp_q[1], iss_instr1_o);
      end
      // two only on both codes two, otherwise one when bit 0 of both is set
      n_pop = ((exp_code == 2'b11) && (iss_rdy_i == 2'b11)) ? 2 :
              ((exp_code[0] && iss_rdy_i[0]) ? 1 : 0);
      repeat (n_pop) begin
        void'(exp_q.pop_front());
        void'(stamp_q.pop_front());
      end
      if (flush_i) begin
        compare_value("mem_rdy_o", 1'b0, mem_rdy_o);
        exp_q.delete();
        stamp_q.delete();
        idle_chk = 1'b1;
      end else if (mem_valid_i && mem_rdy_o) begin
        // odd start keeps the upper instruction only
        if (!mem_odd_i) begin
          exp_q.push_back(mem_data_i[InstrW-1:0]);
          stamp_q.push_back(cyc + 1);
        end
        exp_q.push_back(mem_data_i[BeatW-1:InstrW]);
        stamp_q.push_back(cyc + 1);
      end
      if (stall_on && !flush_i && !mem_rdy_o) begin
        saw_drop = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cyc++;
    if (cyc > CycLimit) begin
      $display("timeout: run went past %0d cycles", CycLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    mem_valid_i = 1'b0;
    mem_odd_i   = 1'b0;
    mem_data_i  = '0;
    iss_rdy_i   = 2'b00;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (RandCyc) drive_cycle(0);
    // long decode stall must back up into the memory side
    stall_on = 1'b1;
    repeat (StallCyc) drive_cycle(1);
    stall_on = 1'b0;
    repeat (RandCyc) drive_cycle(0);
    repeat (DrainCyc) drive_cycle(2);
    @(negedge clk_i);
    #1;
    if (!saw_drop) begin
      errors++;
      $display("mem_rdy_o never dropped during the decode stall");
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d instructions were never issued after the drain", exp_q.size());
    end
    afail = fetch_buffer_top_i.dual_fifo_i.asserts_i.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afail);
    if ((errors == 0) && (afail == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/fetch_pkg.sv
rtl/dual_pair_if.sv
rtl/fetch_unpack.sv
rtl/dual_fifo.sv
rtl/issue_pair.sv
rtl/fetch_buffer_top.sv
dv/fetch_buffer_asserts.sv
dv/fetch_buffer_tb.sv

/* Bender.yml */
package:
  name: fetch_buffer

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/dual_pair_if.sv
      - rtl/fetch_unpack.sv
      - rtl/dual_fifo.sv
      - rtl/issue_pair.sv
      - rtl/fetch_buffer_top.sv
  - target: test
    files:
      - dv/fetch_buffer_asserts.sv
      - dv/fetch_buffer_tb.sv
